/* common/lm80c_defs.svh */
// lm80c memory system constants
// bus widths, cpu enable divider, download start and rom signature
`ifndef LM80C_DEFS_SVH
`define LM80C_DEFS_SVH

// widths
`define RAM_ADDR_W 12              // 4 KiB system ram
`define DATA_W 8                   // z80 data byte

// sys_clock cycles per cpu clock enable
`define CPU_DIV 8

// rom image lands at the bottom of ram
`define ROM_START_ADDR 12'h000

// first four bytes of a valid firmware image
`define SIG_BYTE0 8'hF3            // di
`define SIG_BYTE1 8'hC3            // jp nn opcode
`define SIG_BYTE2 8'h5A            // jump target low
`define SIG_BYTE3 8'h02            // jump target high

`endif

/* common/lm80c_pkg.sv */
// lm80c shared types
// address and data vectors, the ram request bundle that every
// requester drives, and the loader and verifier fsm encodings
`default_nettype none

`include "lm80c_defs.svh"

package lm80c_pkg;

	typedef logic [`RAM_ADDR_W-1:0] ram_addr_t;    // ram word address
	typedef logic [`DATA_W-1:0]     byte_t;        // one data byte

	// one ram access, 22 bits
	typedef struct packed {
		ram_addr_t addr;
		byte_t     wdata;
		logic      we;        // write, only honoured on cpu_ena
		logic      re;        // read request
	} mem_req_t;

	// host download handshake
	typedef enum logic [1:0] {
		LD_IDLE,              // waiting for dl_req
		LD_WRITE,             // byte held, waiting for cpu_ena
		LD_ACK                // ack high until host drops req
	} loader_state_t;

	// boot signature check
	typedef enum logic [1:0] {
		VF_WAIT,
		VF_READ,
		VF_COMPARE,
		VF_DONE
	} verify_state_t;

endpackage

`default_nettype wire

/* source/boot_control.sv */
// boot control
// divides sys_clock down to the one-cycle cpu clock enable and
// registers the cpu reset and wait lines from the loader, eraser,
// verifier and the reset key
`default_nettype none

`include "lm80c_defs.svh"

module boot_control (
	input  logic sys_clock,
	input  logic RESET,
	input  logic rom_loaded,
	input  logic downloading,
	input  logic erasing,
	input  logic verify_done,
	input  logic reset_key,
	output logic cpu_ena,
	output logic cpu_reset,
	output logic cpu_wait
);

	localparam int CNT_W = $clog2(`CPU_DIV);

	logic [CNT_W-1:0] div_cnt;     // position inside the cpu cycle
	logic             reset_next;
	logic             wait_next;

	// free running divider, zero right after reset
	always_ff @(posedge sys_clock) begin
		if (RESET) begin
			div_cnt <= '0;
		end else if (div_cnt == CNT_W'(`CPU_DIV - 1)) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	assign cpu_ena = (div_cnt == '0);    // first cycle of each cpu cycle

	// cpu held in reset until a rom is in, or while erasing
	assign reset_next = !rom_loaded || reset_key || erasing;
	// cpu stalled while loading or until the signature check ends
	assign wait_next  = !rom_loaded || downloading || !verify_done;

	always_ff @(posedge sys_clock) begin
		if (RESET) begin
			cpu_reset <= 1'b1;
			cpu_wait  <= 1'b1;
		end else begin
			cpu_reset <= reset_next;
			cpu_wait  <= wait_next;
		end
	end

	// enable is a single pulse per cpu cycle
	a_ena_pulse: assert property (@(posedge sys_clock) disable iff (RESET)
		cpu_ena |=> !cpu_ena)
		else $error("cpu_ena high in two consecutive cycles");

endmodule

`default_nettype wire

/* memory/mem_arbiter.sv */
// memory arbiter
// fixed priority onto the single ram port:
// loader, then eraser, then verifier, then the cpu port
// cpu writes only pass when no other requester owns the port
`default_nettype none

module mem_arbiter import lm80c_pkg::*; (
	input  mem_req_t loader_req,
	input  mem_req_t eraser_req,
	input  mem_req_t verify_req,
	input  mem_req_t cpu_req,
	input  logic     downloading,
	input  logic     erasing,
	input  logic     verify_busy,
	input  logic     cpu_ena,
	output mem_req_t ram_req
);

	mem_req_t cpu_gated;    // cpu request, write trimmed to the enable

	// the cpu holds its write strobe over a whole cpu cycle
	always_comb begin
		cpu_gated    = cpu_req;
		cpu_gated.we = cpu_req.we & cpu_ena;
	end

	always_comb begin
		if (downloading) begin
			ram_req = loader_req;            // host download wins
		end else if (erasing) begin
			ram_req = eraser_req;
		end else if (verify_busy) begin
			ram_req = verify_req;            // cpu is in wait meanwhile
		end else begin
			ram_req = cpu_gated;
		end
	end

	// loader and eraser time their own strobes to cpu_ena
	always_comb begin
		a_we_on_ena: assert final (!ram_req.we || cpu_ena)
			else $error("ram write outside cpu_ena");
	end

endmodule

`default_nettype wire

/* memory/sysram.sv */
// system ram
// 4 KiB single port, synchronous
// write on cpu_ena with the write strobe set, read data one
// sys_clock after the address on every cycle
`default_nettype none

`include "lm80c_defs.svh"

module sysram import lm80c_pkg::*; (
	input  logic     sys_clock,
	input  mem_req_t ram_req,
	input  logic     cpu_ena,
	output byte_t    rdata
);

	localparam int DEPTH = 1 << `RAM_ADDR_W;

	byte_t mem [DEPTH];

	always_ff @(posedge sys_clock) begin
		if (cpu_ena && ram_req.we) begin
			mem[ram_req.addr] <= ram_req.wdata;
		end
		rdata <= mem[ram_req.addr];          // old data on a same-cycle write
	end

endmodule

`default_nettype wire

/* memory/ram_eraser.sv */
// ram eraser
// on a rising erase_req sweeps every ram address writing zero,
// one address per cpu_ena, erasing stays high for the whole sweep
`default_nettype none

module ram_eraser import lm80c_pkg::*; (
	input  logic     sys_clock,
	input  logic     RESET,
	input  logic     cpu_ena,
	input  logic     erase_req,
	output logic     erasing,
	output mem_req_t req
);

	ram_addr_t addr_r;      // next address to clear
	logic      req_q;       // erase_req one cycle back

	always_ff @(posedge sys_clock) begin
		if (RESET) begin
			erasing <= 1'b0;
			addr_r  <= '0;
			req_q   <= 1'b0;
		end else begin
			req_q <= erase_req;
			if (!erasing) begin
				if (erase_req && !req_q) begin   // rising edge only
					erasing <= 1'b1;
					addr_r  <= '0;
				end
			end else if (cpu_ena) begin
				addr_r <= addr_r + 1'b1;         // wraps back to zero
				if (addr_r == '1) begin
					erasing <= 1'b0;             // last address written
				end
			end
		end
	end

	// first write lands on the first cpu_ena after the edge
	assign req = '{addr: addr_r, wdata: byte_t'(0), we: erasing & cpu_ena, re: 1'b0};

	// sweep moves at cpu speed
	a_addr_on_ena: assert property (@(posedge sys_clock) disable iff (RESET)
		erasing && !cpu_ena |=> $stable(addr_r))
		else $error("eraser address moved without cpu_ena");

endmodule

`default_nettype wire

/* loader/rom_loader.sv */
// rom loader
// host download port with a four-phase req/ack handshake
// each byte is captured, written to ram at the next cpu_ena,
// then acknowledged. rom_loaded latches at the end of a download
// that stored at least one byte
`default_nettype none

`include "lm80c_defs.svh"

module rom_loader import lm80c_pkg::*; (
	input  logic     sys_clock,
	input  logic     RESET,
	input  logic     cpu_ena,
	input  logic     dl_active,
	input  logic     dl_req,
	input  byte_t    dl_data,
	output logic     dl_ack,
	output logic     downloading,
	output logic     rom_loaded,
	output mem_req_t req
);

	loader_state_t state;
	ram_addr_t     addr_r;      // next download address
	byte_t         data_r;      // byte waiting for its write slot
	logic          active_q;    // dl_active one cycle back
	logic          stored;      // a byte went into ram this download

	// payload capture
	always_ff @(posedge sys_clock) begin
		if (state == LD_IDLE && dl_active && dl_req) begin
			data_r <= dl_data;
		end
	end

	always_ff @(posedge sys_clock) begin
		if (RESET) begin
			state      <= LD_IDLE;
			dl_ack     <= 1'b0;
			addr_r     <= `ROM_START_ADDR;
			active_q   <= 1'b0;
			stored     <= 1'b0;
			rom_loaded <= 1'b0;
		end else begin
			active_q <= dl_active;
			if (dl_active && !active_q) begin    // new image starts at the bottom
				addr_r <= `ROM_START_ADDR;
				stored <= 1'b0;
			end
			if (!dl_active && active_q && stored) begin
				rom_loaded <= 1'b1;              // sticky until RESET
			end

			case (state)
				LD_IDLE: begin
					if (dl_active && dl_req) begin
						state <= LD_WRITE;
					end
				end
				LD_WRITE: begin
					if (cpu_ena) begin           // write happens on this edge
						addr_r <= addr_r + 1'b1;
						stored <= 1'b1;
						dl_ack <= 1'b1;
						state  <= LD_ACK;
					end
				end
				LD_ACK: begin
					if (!dl_req) begin           // host released, close the cycle
						dl_ack <= 1'b0;
						state  <= LD_IDLE;
					end
				end
				default: state <= LD_IDLE;
			endcase
		end
	end

	assign downloading = dl_active || (state != LD_IDLE);  // covers the last ack

	assign req = '{addr: addr_r, wdata: data_r, we: (state == LD_WRITE) & cpu_ena,
		re: 1'b0};

	// ack only answers a pending request
	a_ack_after_req: assert property (@(posedge sys_clock) disable iff (RESET)
		$rose(dl_ack) |-> $past(dl_req))
		else $error("dl_ack rose without dl_req");

endmodule

`default_nettype wire

/* source/boot_verifier.sv */
// boot verifier
// once a rom is loaded and the eraser is idle, reads ram
// addresses 0 to 3 and compares them with the rom signature
// boot_ok only on four matches, rerun after every cpu reset
`default_nettype none

`include "lm80c_defs.svh"

module boot_verifier import lm80c_pkg::*; (
	input  logic     sys_clock,
	input  logic     cpu_reset,
	input  logic     cpu_ena,
	input  logic     rom_loaded,
	input  logic     erasing,
	input  byte_t    rdata,
	output mem_req_t req,
	output logic     verify_done,
	output logic     boot_ok
);

	verify_state_t state;
	logic [1:0]    idx;          // signature byte under test
	logic [2:0]    match_cnt;    // bytes matched so far
	logic          hit;
	logic [2:0]    next_cnt;

	function automatic byte_t sig_byte(input logic [1:0] n);
		case (n)
			2'd0:    sig_byte = `SIG_BYTE0;
			2'd1:    sig_byte = `SIG_BYTE1;
			2'd2:    sig_byte = `SIG_BYTE2;
			default: sig_byte = `SIG_BYTE3;
		endcase
	endfunction

	assign hit      = (rdata == sig_byte(idx));      // valid in VF_COMPARE
	assign next_cnt = match_cnt + {2'b00, hit};

	always_ff @(posedge sys_clock) begin
		if (cpu_reset) begin
			state     <= VF_WAIT;
			idx       <= 2'd0;
			match_cnt <= 3'd0;
			boot_ok   <= 1'b0;
		end else begin
			case (state)
				VF_WAIT: begin
					if (rom_loaded && !erasing && cpu_ena) begin
						idx       <= 2'd0;
						match_cnt <= 3'd0;
						state     <= VF_READ;
					end
				end
				VF_READ: begin
					if (cpu_ena) begin           // ram samples the address here
						state <= VF_COMPARE;
					end
				end
				VF_COMPARE: begin
					match_cnt <= next_cnt;
					if (idx == 2'd3) begin
						boot_ok <= (next_cnt == 3'd4);
						state   <= VF_DONE;
					end else begin
						idx   <= idx + 1'b1;
						state <= VF_READ;
					end
				end
				VF_DONE: state <= VF_DONE;      // held until the next cpu reset
				default: state <= VF_WAIT;
			endcase
		end
	end

	assign verify_done = (state == VF_DONE);

	assign req = '{addr: ram_addr_t'(idx), wdata: byte_t'(0), we: 1'b0,
		re: state == VF_READ};

endmodule

`default_nettype wire

/* source/lm80c_memsys.sv */
// lm80c memory and boot control
// host rom download, ram eraser and boot signature check share
// one system ram with the cpu port, cpu enable, reset and wait
// are generated here for the z80 core
`default_nettype none

module lm80c_memsys import lm80c_pkg::*; (
	input  logic     sys_clock,
	input  logic     RESET,
	input  logic     dl_active,
	input  logic     dl_req,
	input  byte_t    dl_data,
	output logic     dl_ack,
	input  logic     erase_req,
	input  logic     reset_key,
	input  mem_req_t cpu_req,
	output byte_t    cpu_rdata,
	output logic     cpu_ena,
	output logic     cpu_reset,
	output logic     cpu_wait,
	output logic     boot_ok
);

	mem_req_t loader_req;
	mem_req_t eraser_req;
	mem_req_t verify_req;
	mem_req_t ram_req;        // winner of arbitration
	logic     downloading;
	logic     rom_loaded;
	logic     erasing;
	logic     verify_done;

	boot_control u_boot_control (
		.sys_clock   (sys_clock),
		.RESET       (RESET),
		.rom_loaded  (rom_loaded),
		.downloading (downloading),
		.erasing     (erasing),
		.verify_done (verify_done),
		.reset_key   (reset_key),
		.cpu_ena     (cpu_ena),
		.cpu_reset   (cpu_reset),
		.cpu_wait    (cpu_wait)
	);

	rom_loader u_rom_loader (
		.sys_clock   (sys_clock),
		.RESET       (RESET),
		.cpu_ena     (cpu_ena),
		.dl_active   (dl_active),
		.dl_req      (dl_req),
		.dl_data     (dl_data),
		.dl_ack      (dl_ack),
		.downloading (downloading),
		.rom_loaded  (rom_loaded),
		.req         (loader_req)
	);

	ram_eraser u_ram_eraser (
		.sys_clock (sys_clock),
		.RESET     (RESET),
		.cpu_ena   (cpu_ena),
		.erase_req (erase_req),
		.erasing   (erasing),
		.req       (eraser_req)
	);

	// verifier restarts with every cpu reset
	boot_verifier u_boot_verifier (
		.sys_clock   (sys_clock),
		.cpu_reset   (cpu_reset),
		.cpu_ena     (cpu_ena),
		.rom_loaded  (rom_loaded),
		.erasing     (erasing),
		.rdata       (cpu_rdata),
		.req         (verify_req),
		.verify_done (verify_done),
		.boot_ok     (boot_ok)
	);

	mem_arbiter u_mem_arbiter (
		.loader_req  (loader_req),
		.eraser_req  (eraser_req),
		.verify_req  (verify_req),
		.cpu_req     (cpu_req),
		.downloading (downloading),
		.erasing     (erasing),
		.verify_busy (!verify_done),   // port stays off the cpu until checked
		.cpu_ena     (cpu_ena),
		.ram_req     (ram_req)
	);

	sysram u_sysram (
		.sys_clock (sys_clock),
		.ram_req   (ram_req),
		.cpu_ena   (cpu_ena),
		.rdata     (cpu_rdata)
	);

endmodule

`default_nettype wire

/* testbench/tb_lm80c_memsys.sv */
// testbench for the lm80c memory and boot control block
// drives the host download port, the cpu port and the erase key,
// keeps a byte array model of the system ram and checks the
// responses with immediate and concurrent assertions
`default_nettype none

`include "lm80c_defs.svh"

module tb_lm80c_memsys import lm80c_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	// rom signature, byte 0 in the low bits
	localparam logic [31:0] SIGNATURE = {`SIG_BYTE3, `SIG_BYTE2, `SIG_BYTE1, `SIG_BYTE0};
	localparam int IMAGE_LEN = 64;
	localparam int ERASE_MIN = 4095 * `CPU_DIV + 1;   // first enable up to CPU_DIV away
	localparam int ERASE_MAX = 4096 * `CPU_DIV;

	logic     sys_clock;
	logic     RESET;
	logic     dl_active;
	logic     dl_req;
	byte_t    dl_data;
	logic     dl_ack;
	logic     erase_req;
	logic     reset_key;
	mem_req_t cpu_req;
	byte_t    cpu_rdata;
	logic     cpu_ena;
	logic     cpu_reset;
	logic     cpu_wait;
	logic     boot_ok;

	byte_t  model [1 << `RAM_ADDR_W];    // expected ram contents
	integer seed;
	int     error_cnt;
	int     fail_cnt;
	int     test_errors;                  // error_cnt when the test began
	int     ena_gap;                      // cycles since the last cpu_ena
	logic   ena_seen;

	lm80c_memsys dut (
		.sys_clock (sys_clock),
		.RESET     (RESET),
		.dl_active (dl_active),
		.dl_req    (dl_req),
		.dl_data   (dl_data),
		.dl_ack    (dl_ack),
		.erase_req (erase_req),
		.reset_key (reset_key),
		.cpu_req   (cpu_req),
		.cpu_rdata (cpu_rdata),
		.cpu_ena   (cpu_ena),
		.cpu_reset (cpu_reset),
		.cpu_wait  (cpu_wait),
		.boot_ok   (boot_ok)
	);

	initial begin
		sys_clock = 1'b0;
		forever #10 sys_clock = ~sys_clock;    // 20 ns period
	end

	// gap counter for the enable spacing check
	always @(posedge sys_clock) begin
		if (RESET) begin
			ena_gap  <= 0;
			ena_seen <= 1'b0;
		end else if (cpu_ena) begin
			ena_gap  <= 0;
			ena_seen <= 1'b1;
		end else begin
			ena_gap <= ena_gap + 1;
		end
	end

	// exactly one enable every CPU_DIV cycles
	a_ena_period: assert property (@(posedge sys_clock) disable iff (RESET)
		ena_seen |-> cpu_ena == (ena_gap == `CPU_DIV - 1))
		else begin
			error_cnt++;
			$display("ERROR %0t cpu_ena got %b expected %b", $time,
				$sampled(cpu_ena), !$sampled(cpu_ena));
		end

	// four-phase rule seen from the loader side
	a_ack_rise: assert property (@(posedge sys_clock) disable iff (RESET)
		$rose(dl_ack) |-> $past(dl_req))
		else begin
			error_cnt++;
			$display("dl_ack rose while dl_req was low at %0t", $time);
		end

	a_ack_fall: assert property (@(posedge sys_clock) disable iff (RESET)
		$fell(dl_ack) |-> !$past(dl_req))
		else begin
			error_cnt++;
			$display("dl_ack fell before dl_req was released at %0t", $time);
		end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else begin
			error_cnt++;
			$display("ERROR %0t %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic finish_test(input int num, input string title);
		if (error_cnt == test_errors) begin
			$display("test %0d %s: ok", num, title);
		end else begin
			fail_cnt++;
			$display("test %0d %s: FAILED with %0d errors", num, title,
				error_cnt - test_errors);
		end
		test_errors = error_cnt;
	endtask

	task automatic apply_reset();
		int i;
		RESET = 1'b1;
		for (i = 0; i < 5; i++) begin
			@(negedge sys_clock);
		end
		RESET = 1'b0;                        // released on a falling edge
	endtask

	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		while (dl_ack !== level && n < 40) begin
			@(negedge sys_clock);
			n++;
		end
		if (dl_ack !== level) begin
			error_cnt++;
			$display("timeout waiting for dl_ack to go %b", level);
		end
	endtask

	task automatic poll_cpu_wait(input logic level, input int limit);
		int n;
		n = 0;
		while (cpu_wait !== level && n < limit) begin
			@(negedge sys_clock);
			n++;
		end
		if (cpu_wait !== level) begin
			error_cnt++;
			$display("timeout waiting for cpu_wait to go %b", level);
		end
	endtask

	task automatic poll_cpu_reset(input logic level, input int limit);
		int n;
		n = 0;
		while (cpu_reset !== level && n < limit) begin
			@(negedge sys_clock);
			n++;
		end
		if (cpu_reset !== level) begin
			error_cnt++;
			$display("timeout waiting for cpu_reset to go %b", level);
		end
	endtask

	// host side of the download, signature then random bytes
	task automatic download_image(input int count, input logic bad_sig);
		int        i;
		byte_t     b;
		ram_addr_t a;
		dl_active = 1'b1;
		@(negedge sys_clock);
		for (i = 0; i < count; i++) begin
			if (i < 4) begin
				b = SIGNATURE[i*8 +: 8];
			end else begin
				b = byte_t'($random(seed));
			end
			if (i == 1 && bad_sig) begin
				b = b ^ 8'h81;                // corrupt the jp opcode
			end
			wait_ack(1'b0);                  // previous cycle closed
			dl_data = b;
			dl_req  = 1'b1;
			a = `ROM_START_ADDR + ram_addr_t'(i);
			model[a] = b;
			wait_ack(1'b1);
			dl_req = 1'b0;
		end
		wait_ack(1'b0);
		dl_active = 1'b0;
		@(negedge sys_clock);
	endtask

	// data checked one cycle after the address
	task automatic read_back(input ram_addr_t base, input int count);
		int        i;
		ram_addr_t a;
		for (i = 0; i < count; i++) begin
			a = base + ram_addr_t'(i);
			cpu_req = '{addr: a, wdata: 8'h00, we: 1'b0, re: 1'b1};
			@(negedge sys_clock);
			check_value($sformatf("cpu_rdata[%03h]", a), cpu_rdata, model[a]);
		end
		cpu_req = '0;
	endtask

	// strobe held until a cpu_ena edge has passed
	task automatic cpu_write(input ram_addr_t a, input byte_t d);
		int n;
		n = 0;
		cpu_req = '{addr: a, wdata: d, we: 1'b1, re: 1'b0};
		while (!cpu_ena && n < 20) begin
			@(negedge sys_clock);
			n++;
		end
		if (!cpu_ena) begin
			error_cnt++;
			$display("timeout waiting for cpu_ena during a cpu write");
		end
		@(negedge sys_clock);               // enable edge now behind us
		cpu_req = '0;
		model[a] = d;
	endtask

	initial begin
		int        n;
		ram_addr_t a;
		seed        = 32'h9216;
		error_cnt   = 0;
		fail_cnt    = 0;
		test_errors = 0;
		RESET       = 1'b1;
		dl_active   = 1'b0;
		dl_req      = 1'b0;
		dl_data     = 8'h00;
		erase_req   = 1'b0;
		reset_key   = 1'b0;
		cpu_req     = '0;
		foreach (model[k]) begin
			model[k] = 8'h00;
		end

		apply_reset();
		check_value("cpu_ena", cpu_ena, 1'b1);    // first cycle after reset
		check_value("cpu_reset", cpu_reset, 1'b1);
		check_value("cpu_wait", cpu_wait, 1'b1);
		check_value("boot_ok", boot_ok, 1'b0);
		check_value("dl_ack", dl_ack, 1'b0);
		finish_test(1, "after reset");

		download_image(IMAGE_LEN, 1'b0);
		poll_cpu_wait(1'b0, 100);
		check_value("boot_ok", boot_ok, 1'b1);
		check_value("cpu_reset", cpu_reset, 1'b0);
		finish_test(2, "correct download");

		read_back(`ROM_START_ADDR, IMAGE_LEN);
		finish_test(3, "cpu read-back");

		a = 12'h100 | ram_addr_t'($random(seed) & 8'hff);
		cpu_write(a, byte_t'($random(seed)));
		cpu_write(12'h010, byte_t'($random(seed)));   // over the image
		read_back(a, 1);
		read_back(12'h010, 1);
		finish_test(4, "cpu write");

		erase_req = 1'b1;
		@(negedge sys_clock);
		@(negedge sys_clock);
		erase_req = 1'b0;
		poll_cpu_reset(1'b1, 10);
		n = 0;
		while (cpu_reset && n < ERASE_MAX + 100) begin   // sweep length
			@(negedge sys_clock);
			n++;
		end
		assert (n >= ERASE_MIN && n <= ERASE_MAX)
		else begin
			error_cnt++;
			$display("ERROR %0t cpu_reset high cycles got %0d expected %0d to %0d",
				$time, n, ERASE_MIN, ERASE_MAX);
		end
		foreach (model[k]) begin
			model[k] = 8'h00;
		end
		poll_cpu_wait(1'b0, 100);          // verifier reruns on zeros
		check_value("boot_ok", boot_ok, 1'b0);
		read_back(12'h000, IMAGE_LEN);
		for (int i = 0; i < 8; i++) begin
			read_back(ram_addr_t'($random(seed)), 1);
		end
		finish_test(5, "erase");

		apply_reset();
		download_image(IMAGE_LEN, 1'b1);
		poll_cpu_wait(1'b0, 100);
		check_value("boot_ok", boot_ok, 1'b0);
		check_value("cpu_reset", cpu_reset, 1'b0);
		finish_test(6, "wrong signature");

		$display("tests run 6, failed %0d, errors %0d", fail_cnt, error_cnt);
		if (error_cnt == 0 && fail_cnt == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+common
common/lm80c_pkg.sv
source/boot_control.sv
memory/mem_arbiter.sv
memory/sysram.sv
memory/ram_eraser.sv
loader/rom_loader.sv
source/boot_verifier.sv
source/lm80c_memsys.sv
testbench/tb_lm80c_memsys.sv

/* Bender.yml */
package:
  name: lm80c_memsys

sources:
  - include_dirs:
      - common
    files:
      - common/lm80c_pkg.sv
      - source/boot_control.sv
      - memory/mem_arbiter.sv
      - memory/sysram.sv
      - memory/ram_eraser.sv
      - loader/rom_loader.sv
      - source/boot_verifier.sv
      - source/lm80c_memsys.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/tb_lm80c_memsys.sv
